/* src/dwc_pkg.sv */
package dwc_pkg;

  // Bus widths
  localparam int addr_width   = 32;
  localparam int id_width     = 4;
  localparam int wide_width   = 64;
  localparam int narrow_width = 32;

  // Burst decision queue
  localparam int queue_depth      = 4;
  localparam int queue_addr_width = $clog2(queue_depth);

  // AXI transfer size codes
  localparam logic [2:0] size_narrow = 3'd2;
  localparam logic [2:0] size_wide   = 3'd3;

  typedef struct packed {
    logic [id_width-1:0]   id;
    logic [addr_width-1:0] addr;
    logic [7:0]            len;
    logic [2:0]            size;
    logic [1:0]            burst;
  } ax_t;

  // Low lane sits in the lower bits of the wide word
  typedef struct packed {
    logic [narrow_width-1:0] hi;
    logic [narrow_width-1:0] lo;
  } lane_pair_t;

  typedef union packed {
    logic [wide_width-1:0] word;
    lane_pair_t            lanes;
  } wide_data_u;

  typedef struct packed {
    wide_data_u              data;
    logic [wide_width/8-1:0] strb;
    logic                    last;
  } w_wide_t;

  typedef struct packed {
    logic [narrow_width-1:0]   data;
    logic [narrow_width/8-1:0] strb;
    logic                      last;
  } w_narrow_t;

  typedef struct packed {
    logic [id_width-1:0] id;
    wide_data_u          data;
    logic [1:0]          resp;
    logic                last;
  } r_wide_t;

  typedef struct packed {
    logic [id_width-1:0]     id;
    logic [narrow_width-1:0] data;
    logic [1:0]              resp;
    logic                    last;
  } r_narrow_t;

  typedef struct packed {
    logic [id_width-1:0] id;
    logic [1:0]          resp;
  } b_t;

  // Per-burst decision handed from the address path to the data path
  typedef struct packed {
    logic       split;
    logic       start_lane;
    logic [7:0] len;
  } burst_info_t;

endpackage

/* src/dwc_ax_resize.sv */
`timescale 1ns/100ps

module dwc_ax_resize (
  input  logic                clk,
  input  logic                rst_n,
  input  dwc_pkg::ax_t        wide_ax,
  input  logic                wide_valid,
  output logic                wide_ready,
  output dwc_pkg::ax_t        narrow_ax,
  output logic                narrow_valid,
  input  logic                narrow_ready,
  output dwc_pkg::burst_info_t info,
  output logic                info_valid,
  input  logic                info_ready
);
  import dwc_pkg::*;

  burst_info_t               info_mem [queue_depth];
  logic [queue_addr_width:0] wr_ptr;
  logic [queue_addr_width:0] rd_ptr;
  logic                      full;
  logic                      empty;
  logic                      push;
  logic                      pop;
  logic                      split;

  assign split = (wide_ax.size == size_wide);

  // Full when the indices match but the wrap bits differ
  assign empty = (wr_ptr == rd_ptr);
  assign full  = (wr_ptr[queue_addr_width] != rd_ptr[queue_addr_width]) &&
                 (wr_ptr[queue_addr_width-1:0] == rd_ptr[queue_addr_width-1:0]);

  // Size 3 bursts become twice as many size 2 beats
  always_comb begin
    narrow_ax = wide_ax;
    if (split) begin
      narrow_ax.size = size_narrow;
      narrow_ax.len  = {wide_ax.len[6:0], 1'b1};
    end
  end

  assign narrow_valid = wide_valid && !full;
  assign wide_ready   = narrow_ready && !full;
  assign push         = wide_valid && wide_ready;

  assign info       = info_mem[rd_ptr[queue_addr_width-1:0]];
  assign info_valid = !empty;
  assign pop        = info_valid && info_ready;

  always_ff @(posedge clk) begin
    if (push) begin
      info_mem[wr_ptr[queue_addr_width-1:0]] <= '{
        split:      split,
        start_lane: wide_ax.addr[2],
        len:        wide_ax.len
      };
    end
  end

  always_ff @(posedge clk or negedge rst_n) begin
    if (!rst_n) begin
      wr_ptr <= '0;
      rd_ptr <= '0;
    end else begin
      if (push) wr_ptr <= wr_ptr + 1'b1;
      if (pop)  rd_ptr <= rd_ptr + 1'b1;
    end
  end

endmodule

/* src/dwc_w_split.sv */
`timescale 1ns/100ps

module dwc_w_split (
  input  logic                 clk,
  input  logic                 rst_n,
  input  dwc_pkg::burst_info_t info,
  input  logic                 info_valid,
  output logic                 info_ready,
  input  dwc_pkg::w_wide_t     wide_w,
  input  logic                 wide_valid,
  output logic                 wide_ready,
  output dwc_pkg::w_narrow_t   narrow_w,
  output logic                 narrow_valid,
  input  logic                 narrow_ready
);

  // High half of a split beat is pending
  logic half_q;
  // Odd beat within an unsplit burst
  logic beat_odd_q;
  logic lane;
  logic use_hi;
  logic narrow_fire;
  logic wide_fire;

  assign lane   = info.start_lane ^ beat_odd_q;
  assign use_hi = info.split ? half_q : lane;

  // Stall everything until a decision is queued
  assign narrow_valid = info_valid && wide_valid;

  always_comb begin
    narrow_w.data = use_hi ? wide_w.data.lanes.hi : wide_w.data.lanes.lo;
    narrow_w.strb = use_hi ? wide_w.strb[7:4] : wide_w.strb[3:0];
    narrow_w.last = wide_w.last && (!info.split || half_q);
  end

  // Low lane of a split beat leaves the wide beat in place
  assign wide_ready = info_valid && narrow_ready && (!info.split || half_q);

  assign narrow_fire = narrow_valid && narrow_ready;
  assign wide_fire   = wide_valid && wide_ready;
  assign info_ready  = wide_fire && wide_w.last;

  always_ff @(posedge clk or negedge rst_n) begin
    if (!rst_n) begin
      half_q     <= 1'b0;
      beat_odd_q <= 1'b0;
    end else if (narrow_fire) begin
      if (info.split) begin
        half_q <= !half_q;
      end else if (wide_w.last) begin
        beat_odd_q <= 1'b0;
      end else begin
        beat_odd_q <= !beat_odd_q;
      end
    end
  end

endmodule

/* src/dwc_r_merge.sv */
`timescale 1ns/100ps

module dwc_r_merge (
  input  logic                 clk,
  input  logic                 rst_n,
  input  dwc_pkg::burst_info_t info,
  input  logic                 info_valid,
  output logic                 info_ready,
  input  dwc_pkg::r_narrow_t   narrow_r,
  input  logic                 narrow_valid,
  output logic                 narrow_ready,
  output dwc_pkg::r_wide_t     wide_r,
  output logic                 wide_valid,
  input  logic                 wide_ready
);
  import dwc_pkg::*;

  // Stored low half of a split pair
  logic [narrow_width-1:0] lo_q;
  logic [1:0]              resp_q;
  logic                    full_q;
  // Wide beats delivered so far in this burst
  logic [7:0]              beat_cnt_q;
  logic                    lane;
  logic                    store;
  logic                    wide_fire;
  logic                    last_beat;

  assign lane      = info.start_lane ^ beat_cnt_q[0];
  assign last_beat = (beat_cnt_q == info.len);

  always_comb begin
    if (info.split) begin
      narrow_ready = info_valid && (!full_q || wide_ready);
      wide_valid   = info_valid && full_q && narrow_valid;
    end else begin
      narrow_ready = info_valid && wide_ready;
      wide_valid   = info_valid && narrow_valid;
    end
  end

  always_comb begin
    wide_r.id   = narrow_r.id;
    wide_r.last = narrow_r.last;
    if (info.split) begin
      wide_r.data.lanes.lo = lo_q;
      wide_r.data.lanes.hi = narrow_r.data;
      // Worse of the two response codes
      wide_r.resp = (narrow_r.resp > resp_q) ? narrow_r.resp : resp_q;
    end else begin
      wide_r.data.lanes.lo = lane ? '0 : narrow_r.data;
      wide_r.data.lanes.hi = lane ? narrow_r.data : '0;
      wide_r.resp          = narrow_r.resp;
    end
  end

  assign store      = info.split && !full_q && narrow_valid && narrow_ready;
  assign wide_fire  = wide_valid && wide_ready;
  assign info_ready = wide_fire && last_beat;

  always_ff @(posedge clk) begin
    if (store) begin
      lo_q   <= narrow_r.data;
      resp_q <= narrow_r.resp;
    end
  end

  always_ff @(posedge clk or negedge rst_n) begin
    if (!rst_n) begin
      full_q     <= 1'b0;
      beat_cnt_q <= '0;
    end else begin
      if (store) begin
        full_q <= 1'b1;
      end else if (wide_fire) begin
        full_q <= 1'b0;
      end
      if (wide_fire) begin
        beat_cnt_q <= last_beat ? '0 : beat_cnt_q + 1'b1;
      end
    end
  end

endmodule

/* src/dwc_downsizer.sv */
`timescale 1ns/100ps

module dwc_downsizer (
  input  logic               clk,
  input  logic               rst_n,
  // Wide master side
  input  dwc_pkg::ax_t       s_aw,
  input  logic               s_aw_valid,
  output logic               s_aw_ready,
  input  dwc_pkg::w_wide_t   s_w,
  input  logic               s_w_valid,
  output logic               s_w_ready,
  output dwc_pkg::b_t        s_b,
  output logic               s_b_valid,
  input  logic               s_b_ready,
  input  dwc_pkg::ax_t       s_ar,
  input  logic               s_ar_valid,
  output logic               s_ar_ready,
  output dwc_pkg::r_wide_t   s_r,
  output logic               s_r_valid,
  input  logic               s_r_ready,
  // Narrow slave side
  output dwc_pkg::ax_t       m_aw,
  output logic               m_aw_valid,
  input  logic               m_aw_ready,
  output dwc_pkg::w_narrow_t m_w,
  output logic               m_w_valid,
  input  logic               m_w_ready,
  input  dwc_pkg::b_t        m_b,
  input  logic               m_b_valid,
  output logic               m_b_ready,
  output dwc_pkg::ax_t       m_ar,
  output logic               m_ar_valid,
  input  logic               m_ar_ready,
  input  dwc_pkg::r_narrow_t m_r,
  input  logic               m_r_valid,
  output logic               m_r_ready
);
  import dwc_pkg::*;

  burst_info_t aw_info;
  logic        aw_info_valid;
  logic        aw_info_ready;
  burst_info_t ar_info;
  logic        ar_info_valid;
  logic        ar_info_ready;

  // Write path
  dwc_ax_resize aw_resize_i (
    .clk          (clk),
    .rst_n        (rst_n),
    .wide_ax      (s_aw),
    .wide_valid   (s_aw_valid),
    .wide_ready   (s_aw_ready),
    .narrow_ax    (m_aw),
    .narrow_valid (m_aw_valid),
    .narrow_ready (m_aw_ready),
    .info         (aw_info),
    .info_valid   (aw_info_valid),
    .info_ready   (aw_info_ready)
  );

  dwc_w_split w_split_i (
    .clk          (clk),
    .rst_n        (rst_n),
    .info         (aw_info),
    .info_valid   (aw_info_valid),
    .info_ready   (aw_info_ready),
    .wide_w       (s_w),
    .wide_valid   (s_w_valid),
    .wide_ready   (s_w_ready),
    .narrow_w     (m_w),
    .narrow_valid (m_w_valid),
    .narrow_ready (m_w_ready)
  );

  // Read path
  dwc_ax_resize ar_resize_i (
    .clk          (clk),
    .rst_n        (rst_n),
    .wide_ax      (s_ar),
    .wide_valid   (s_ar_valid),
    .wide_ready   (s_ar_ready),
    .narrow_ax    (m_ar),
    .narrow_valid (m_ar_valid),
    .narrow_ready (m_ar_ready),
    .info         (ar_info),
    .info_valid   (ar_info_valid),
    .info_ready   (ar_info_ready)
  );

  dwc_r_merge r_merge_i (
    .clk          (clk),
    .rst_n        (rst_n),
    .info         (ar_info),
    .info_valid   (ar_info_valid),
    .info_ready   (ar_info_ready),
    .narrow_r     (m_r),
    .narrow_valid (m_r_valid),
    .narrow_ready (m_r_ready),
    .wide_r       (s_r),
    .wide_valid   (s_r_valid),
    .wide_ready   (s_r_ready)
  );

  // Write responses need no conversion
  assign s_b       = m_b;
  assign s_b_valid = m_b_valid;
  assign m_b_ready = s_b_ready;

endmodule

/* sim/dwc_ref.svh */
`ifndef DWC_REF_SVH
`define DWC_REF_SVH

// Lane used by beat k of an unsplit burst, 1 means the high lane
function automatic logic ref_lane(input logic [addr_width-1:0] addr, input int k);
  return addr[2] ^ k[0];
endfunction

// Narrow address beat expected for a wide address beat
function automatic ax_t ref_narrow_ax(input ax_t wide);
  ax_t narrow;
  narrow = wide;
  if (wide.size == 3'd3) begin
    narrow.size = 3'd2;
    narrow.len  = 8'(2 * int'(wide.len) + 1);
  end
  return narrow;
endfunction

// Narrow beat k of a wide write burst
function automatic w_narrow_t ref_w_beats(input ax_t aw, input w_wide_t burst[$], input int k);
  w_narrow_t n;
  w_wide_t   w;
  logic      hi;
  int        last_k;
  if (aw.size == 3'd3) begin
    w      = burst[k / 2];
    hi     = k[0];
    last_k = 2 * int'(aw.len) + 1;
  end else begin
    w      = burst[k];
    hi     = ref_lane(aw.addr, k);
    last_k = int'(aw.len);
  end
  n.data = hi ? w.data.word[63:32] : w.data.word[31:0];
  n.strb = hi ? w.strb[7:4] : w.strb[3:0];
  n.last = (k == last_k);
  return n;
endfunction

// Wide read beat idx built from the narrow beats the slave sent
function automatic r_wide_t ref_r_beat(input ax_t ar, input r_narrow_t first,
                                       input r_narrow_t second, input int idx);
  r_wide_t w;
  w.id   = first.id;
  w.last = (idx == int'(ar.len));
  if (ar.size == 3'd3) begin
    w.data.word = {second.data, first.data};
    // Higher code is the worse response
    w.resp = (second.resp > first.resp) ? second.resp : first.resp;
  end else begin
    w.data.word = ref_lane(ar.addr, idx) ? {first.data, 32'h0} : {32'h0, first.data};
    w.resp      = first.resp;
  end
  return w;
endfunction

`endif

/* sim/tb_dwc_downsizer.sv */
`timescale 1ns/100ps

module tb_dwc_downsizer;
  import dwc_pkg::*;

  localparam int n_bursts = 40;
  localparam int max_wait = 2000;
  // Channel codes for the wait helpers
  localparam int ch_aw = 0;
  localparam int ch_w  = 1;
  localparam int ch_ar = 2;
  localparam int ch_b  = 3;
  localparam int ch_r  = 4;

  logic      clk;
  logic      rst_n;
  ax_t       s_aw;
  logic      s_aw_valid;
  logic      s_aw_ready;
  w_wide_t   s_w;
  logic      s_w_valid;
  logic      s_w_ready;
  b_t        s_b;
  logic      s_b_valid;
  logic      s_b_ready;
  ax_t       s_ar;
  logic      s_ar_valid;
  logic      s_ar_ready;
  r_wide_t   s_r;
  logic      s_r_valid;
  logic      s_r_ready;
  ax_t       m_aw;
  logic      m_aw_valid;
  logic      m_aw_ready;
  w_narrow_t m_w;
  logic      m_w_valid;
  logic      m_w_ready;
  b_t        m_b;
  logic      m_b_valid;
  logic      m_b_ready;
  ax_t       m_ar;
  logic      m_ar_valid;
  logic      m_ar_ready;
  r_narrow_t m_r;
  logic      m_r_valid;
  logic      m_r_ready;

  dwc_downsizer dut_i (.*);

  `include "dwc_ref.svh"

  logic [31:0] rng = 32'd47364;
  ax_t         wr_ax [n_bursts];
  ax_t         rd_ax [n_bursts];
  b_t          b_drive [n_bursts];
  w_wide_t     w_drive_q [$];
  r_narrow_t   r_drive_q [$];
  ax_t         exp_aw_q [$];
  ax_t         exp_ar_q [$];
  w_narrow_t   exp_w_q [$];
  r_wide_t     exp_r_q [$];
  b_t          exp_b_q [$];
  int          aw_seen = 0;
  int          ar_seen = 0;
  int          w_seen = 0;
  int          w_last_seen = 0;
  int          r_seen = 0;
  int          b_seen = 0;
  int          value_errors = 0;
  int          other_errors = 0;
  int          timeouts = 0;

  initial begin
    clk = 1'b0;
    forever #20 clk = ~clk;
  end

  function automatic logic [31:0] xorshift();
    rng = rng ^ (rng << 13);
    rng = rng ^ (rng >> 17);
    rng = rng ^ (rng << 5);
    return rng;
  endfunction

  // Ready high on three cycles out of four
  function automatic logic ready_draw();
    logic [31:0] r;
    r = xorshift();
    return r[1:0] != 2'b00;
  endfunction

  function automatic ax_t random_ax();
    ax_t         a;
    logic [31:0] r;
    r       = xorshift();
    a.id    = r[3:0];
    a.size  = r[4] ? 3'd3 : 3'd2;
    a.len   = {4'h0, r[11:8]};
    a.burst = 2'b01;
    a.addr  = xorshift();
    a.addr[1:0] = 2'b00;
    if (a.size == 3'd3) begin
      a.addr[2] = 1'b0;
    end
    return a;
  endfunction

  function automatic logic ready_of(input int ch);
    case (ch)
      ch_aw:   return s_aw_ready;
      ch_w:    return s_w_ready;
      ch_ar:   return s_ar_ready;
      ch_b:    return m_b_ready;
      default: return m_r_ready;
    endcase
  endfunction

  function automatic int progress_of(input int ch);
    return (ch == ch_ar) ? ar_seen : w_last_seen;
  endfunction

  function automatic int pending_beats();
    return exp_aw_q.size() + exp_ar_q.size() + exp_w_q.size() + exp_r_q.size() +
           exp_b_q.size();
  endfunction

  task automatic finish_run();
    $display("Errors: %0d wrong values, %0d other failures, %0d timeouts",
             value_errors, other_errors, timeouts);
    if (value_errors + other_errors + timeouts == 0) begin
      $display("Simulation finished: PASS");
    end else begin
      $display("Simulation finished: FAIL");
    end
    $finish;
  endtask

  task automatic stop_on_timeout(input string what);
    timeouts++;
    $display("Timeout: no progress on %s within %0d cycles", what, max_wait);
    finish_run();
  endtask

  // Valid is already up, returns on the falling edge after the transfer
  task automatic await_ready(input int ch, input string what);
    int t;
    t = 0;
    do begin
      @(posedge clk);
      t++;
    end while (!ready_of(ch) && t < max_wait);
    if (!ready_of(ch)) begin
      stop_on_timeout(what);
    end else begin
      @(negedge clk);
    end
  endtask

  task automatic await_progress(input int ch, input int count, input string what);
    int t;
    t = 0;
    while (progress_of(ch) <= count && t < max_wait) begin
      @(negedge clk);
      t++;
    end
    if (progress_of(ch) <= count) begin
      stop_on_timeout(what);
    end
  endtask

  task automatic check_ax(input string name, input ax_t exp, input ax_t act);
    if (exp !== act) begin
      value_errors++;
      $display("** Error %s: expected %h, actual %h", name, exp, act);
    end
  endtask

  task automatic check_w_narrow(input string name, input w_narrow_t exp, input w_narrow_t act);
    if (exp !== act) begin
      value_errors++;
      $display("** Error %s: expected %h, actual %h", name, exp, act);
    end
  endtask

  task automatic check_r_wide(input string name, input r_wide_t exp, input r_wide_t act);
    if (exp !== act) begin
      value_errors++;
      $display("** Error %s: expected %h, actual %h", name, exp, act);
    end
  endtask

  task automatic check_b(input string name, input b_t exp, input b_t act);
    if (exp !== act) begin
      value_errors++;
      $display("** Error %s: expected %h, actual %h", name, exp, act);
    end
  endtask

  task automatic report_extra(input string name);
    other_errors++;
    $display("Unexpected beat on %s with no expected beat left", name);
  endtask

  // Bursts, wide write data, slave responses and every expected output, all in order
  task automatic build_stimulus();
    ax_t         a;
    w_wide_t     burst [$];
    w_wide_t     w;
    r_narrow_t   beats [$];
    r_narrow_t   n;
    b_t          b;
    logic [31:0] r;
    int          nb;
    for (int j = 0; j < n_bursts; j++) begin
      a        = random_ax();
      wr_ax[j] = a;
      exp_aw_q.push_back(ref_narrow_ax(a));
      burst = {};
      for (int i = 0; i <= int'(a.len); i++) begin
        r           = xorshift();
        w.data.word = {xorshift(), xorshift()};
        w.strb      = r[7:0];
        w.last      = (i == int'(a.len));
        burst.push_back(w);
        w_drive_q.push_back(w);
      end
      nb = (int'(a.len) + 1) * ((a.size == 3'd3) ? 2 : 1);
      for (int k = 0; k < nb; k++) begin
        exp_w_q.push_back(ref_w_beats(a, burst, k));
      end
      r          = xorshift();
      b.id       = a.id;
      b.resp     = r[1:0];
      b_drive[j] = b;
      exp_b_q.push_back(b);

      a        = random_ax();
      rd_ax[j] = a;
      exp_ar_q.push_back(ref_narrow_ax(a));
      nb    = (int'(a.len) + 1) * ((a.size == 3'd3) ? 2 : 1);
      beats = {};
      for (int k = 0; k < nb; k++) begin
        r      = xorshift();
        n.id   = a.id;
        n.data = xorshift();
        n.resp = r[1:0];
        n.last = (k == nb - 1);
        beats.push_back(n);
        r_drive_q.push_back(n);
      end
      for (int i = 0; i <= int'(a.len); i++) begin
        if (a.size == 3'd3) begin
          exp_r_q.push_back(ref_r_beat(a, beats[2*i], beats[2*i+1], i));
        end else begin
          exp_r_q.push_back(ref_r_beat(a, beats[i], beats[i], i));
        end
      end
    end
  endtask

  task automatic drive_aw();
    for (int j = 0; j < n_bursts; j++) begin
      s_aw       = wr_ax[j];
      s_aw_valid = 1'b1;
      await_ready(ch_aw, "s_aw handshake");
      s_aw_valid = 1'b0;
    end
  endtask

  task automatic drive_ar();
    for (int j = 0; j < n_bursts; j++) begin
      s_ar       = rd_ax[j];
      s_ar_valid = 1'b1;
      await_ready(ch_ar, "s_ar handshake");
      s_ar_valid = 1'b0;
    end
  endtask

  task automatic drive_w();
    foreach (w_drive_q[i]) begin
      s_w       = w_drive_q[i];
      s_w_valid = 1'b1;
      await_ready(ch_w, "s_w handshake");
      s_w_valid = 1'b0;
    end
  endtask

  // Slave model, one response per completed narrow write burst
  task automatic answer_b();
    for (int j = 0; j < n_bursts; j++) begin
      await_progress(ch_w, j, "last m_w beat");
      m_b       = b_drive[j];
      m_b_valid = 1'b1;
      await_ready(ch_b, "m_b handshake");
      m_b_valid = 1'b0;
    end
  endtask

  // Slave model for reads, sends each burst's beats once its narrow AR is seen
  task automatic answer_r();
    int idx;
    int total;
    idx = 0;
    for (int j = 0; j < n_bursts; j++) begin
      await_progress(ch_ar, j, "m_ar beat");
      total = (int'(rd_ax[j].len) + 1) * ((rd_ax[j].size == 3'd3) ? 2 : 1);
      for (int k = 0; k < total; k++) begin
        m_r       = r_drive_q[idx];
        m_r_valid = 1'b1;
        await_ready(ch_r, "m_r handshake");
        m_r_valid = 1'b0;
        idx++;
      end
    end
  endtask

  task automatic await_drain();
    int t;
    t = 0;
    while (pending_beats() != 0 && t < max_wait) begin
      @(negedge clk);
      t++;
    end
    if (pending_beats() != 0) begin
      other_errors++;
      $display("%0d expected beats never appeared at the outputs", pending_beats());
    end
  endtask

  // Random sink readies
  initial begin
    m_aw_ready = 1'b0;
    m_w_ready  = 1'b0;
    m_ar_ready = 1'b0;
    s_r_ready  = 1'b0;
    s_b_ready  = 1'b0;
    forever begin
      @(negedge clk);
      m_aw_ready = ready_draw();
      m_w_ready  = ready_draw();
      m_ar_ready = ready_draw();
      s_r_ready  = ready_draw();
      s_b_ready  = ready_draw();
    end
  end

  // Output monitor
  always @(posedge clk) begin
    if (rst_n) begin
      if (m_aw_valid && m_aw_ready) begin
        if (exp_aw_q.size() == 0) begin
          report_extra("m_aw");
        end else begin
          check_ax($sformatf("m_aw beat %0d", aw_seen), exp_aw_q.pop_front(), m_aw);
        end
        aw_seen++;
      end
      if (m_ar_valid && m_ar_ready) begin
        if (exp_ar_q.size() == 0) begin
          report_extra("m_ar");
        end else begin
          check_ax($sformatf("m_ar beat %0d", ar_seen), exp_ar_q.pop_front(), m_ar);
        end
        ar_seen++;
      end
      if (m_w_valid && m_w_ready) begin
        if (exp_w_q.size() == 0) begin
          report_extra("m_w");
        end else begin
          check_w_narrow($sformatf("m_w beat %0d", w_seen), exp_w_q.pop_front(), m_w);
        end
        w_seen++;
        if (m_w.last) begin
          w_last_seen++;
        end
      end
      if (s_r_valid && s_r_ready) begin
        if (exp_r_q.size() == 0) begin
          report_extra("s_r");
        end else begin
          check_r_wide($sformatf("s_r beat %0d", r_seen), exp_r_q.pop_front(), s_r);
        end
        r_seen++;
      end
      if (s_b_valid && s_b_ready) begin
        if (exp_b_q.size() == 0) begin
          report_extra("s_b");
        end else begin
          check_b($sformatf("s_b beat %0d", b_seen), exp_b_q.pop_front(), s_b);
        end
        b_seen++;
      end
    end
  end

  initial begin
    rst_n      = 1'b0;
    s_aw       = '0;
    s_aw_valid = 1'b0;
    s_w        = '0;
    s_w_valid  = 1'b0;
    s_ar       = '0;
    s_ar_valid = 1'b0;
    m_b        = '0;
    m_b_valid  = 1'b0;
    m_r        = '0;
    m_r_valid  = 1'b0;
    build_stimulus();
    repeat (16) @(posedge clk);
    @(negedge clk);
    rst_n = 1'b1;
    fork
      drive_aw();
      drive_w();
      drive_ar();
      answer_b();
      answer_r();
    join
    await_drain();
    finish_run();
  end

endmodule

/* build.f */
+incdir+sim
src/dwc_pkg.sv
src/dwc_ax_resize.sv
src/dwc_w_split.sv
src/dwc_r_merge.sv
src/dwc_downsizer.sv
sim/tb_dwc_downsizer.sv

/* Makefile */
# Verilator build and run for the AXI downsizer testbench

VERILATOR ?= verilator
TOP       ?= tb_dwc_downsizer
FILELIST  ?= build.f
OBJ_DIR   ?= obj_dir
VFLAGS    ?= --binary --timing -Wno-fatal
PASS_MSG  ?= Simulation finished: PASS

.PHONY: help test clean

help:
	@echo "Targets:"
	@echo "  test   build with Verilator, run the testbench and check for a pass"
	@echo "  clean  remove the Verilator build directory"
	@echo "Variables: VERILATOR TOP FILELIST OBJ_DIR VFLAGS PASS_MSG"

test:
	$(VERILATOR) $(VFLAGS) --top-module $(TOP) --Mdir $(OBJ_DIR) -f $(FILELIST)
	@out="$$(./$(OBJ_DIR)/V$(TOP))"; \
	echo "$$out"; \
	echo "$$out" | grep -qxF "$(PASS_MSG)"

clean:
	rm -rf $(OBJ_DIR)
